// File: build.f
+incdir+test
logic/mem_pkg.sv
logic/sram_1r1w.sv
logic/bank_map.sv
logic/write_steer.sv
logic/read_path.sv
logic/mp_mem_top.sv
test/tb_mp_mem.sv

// File: Bender.yml
package:
  name: mp_mem

sources:
  - logic/mem_pkg.sv
  - logic/sram_1r1w.sv
  - logic/bank_map.sv
  - logic/write_steer.sv
  - logic/read_path.sv
  - logic/mp_mem_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mp_mem.sv

// File: test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// x^32 + x^22 + x^2 + x + 1, one step per bit.
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    val  = {val[30:0], fb};
  end
  return val;
endfunction

function automatic data_t fill_word(input addr_t adr);
  return {2'b10, ~adr, adr, 2'b01};
endfunction

// inputs change 1 unit after the edge.
task automatic drive_cycle(input logic [1:0] wr, input addr_t a0, input data_t d0,
                           input addr_t a1, input data_t d1, input logic rd,
                           input addr_t ra);
  @(posedge clk);
  #1;
  write     = wr;
  wr_adr[0] = a0;
  din[0]    = d0;
  wr_adr[1] = a1;
  din[1]    = d1;
  read      = rd;
  rd_adr    = ra;
endtask

task automatic drive_idle();
  drive_cycle(2'b00, '0, '0, '0, '0, 1'b0, '0);
endtask

// entered in the cycle after the read was issued.
task automatic await_read(input addr_t adr, input data_t exp);
  int lat;
  lat = 1;
  @(negedge clk);
  while (!rd_vld && lat < 10) begin
    @(negedge clk);
    lat++;
  end
  assert (rd_vld) else begin
    $display("%s: no rd_vld for read of %h", test_name, adr);
    n_other_err++;
  end
  assert (lat == RD_LAT) else begin
    $display("%s: read of %h took %0d cycles", test_name, adr, lat);
    n_other_err++;
  end
  assert (rd_dout === exp) else begin
    $display("error %s: addr %h expected %h actual %h", test_name, adr, exp, rd_dout);
    n_data_err++;
  end
endtask

task automatic read_expect(input addr_t adr, input data_t exp);
  drive_cycle(2'b00, '0, '0, '0, '0, 1'b1, adr);
  drive_idle();
  await_read(adr, exp);
endtask

task automatic wait_reads_done();
  int waited;
  waited = 0;
  while (exp_q.size() > 0 && waited < 20) begin
    @(negedge clk);
    waited++;
  end
  assert (exp_q.size() == 0) else begin
    $display("%s: %0d reads still outstanding", test_name, exp_q.size());
    n_other_err++;
  end
endtask

task automatic reset_and_single_write();
  test_name = "reset_single_write";
  assert (rd_vld === 1'b0) else begin
    $display("rd_vld is not low after reset");
    n_other_err++;
  end
  drive_cycle(2'b01, 6'h13, 16'h5a3c, '0, '0, 1'b0, '0);
  drive_idle();
  read_expect(6'h13, 16'h5a3c);
endtask

task automatic dual_write_banks();
  test_name = "dual_write";
  drive_cycle(2'b11, 6'h05, 16'hc0de, 6'h26, 16'h7e57, 1'b0, '0);  // rows 1 and 9.
  drive_idle();
  read_expect(6'h05, 16'hc0de);
  read_expect(6'h26, 16'h7e57);
endtask

task automatic same_address_writes();
  test_name = "same_address";
  drive_cycle(2'b11, 6'h2b, 16'haaaa, 6'h2b, 16'h5555, 1'b0, '0);
  drive_idle();
  read_expect(6'h2b, 16'h5555);
endtask

task automatic read_during_write();
  test_name = "read_during_write";
  drive_cycle(2'b01, 6'h31, 16'h1234, '0, '0, 1'b0, '0);
  drive_cycle(2'b10, '0, '0, 6'h31, 16'h4321, 1'b1, 6'h31);
  drive_idle();
  await_read(6'h31, 16'h1234);
  read_expect(6'h31, 16'h4321);
endtask

// pairs i and i+32 share a logical bank, so every cycle remaps.
task automatic fill_memory();
  test_name = "fill";
  for (int i = 0; i < NUM_WORDS / 2; i++) begin
    drive_cycle(2'b11, addr_t'(i), fill_word(addr_t'(i)),
                addr_t'(i + NUM_WORDS / 2), fill_word(addr_t'(i + NUM_WORDS / 2)),
                1'b0, '0);
  end
  drive_idle();
endtask

task automatic bank_conflict_writes();
  addr_t a0;
  addr_t a1;
  row_t  row1;
  data_t d0;
  data_t d1;
  test_name = "bank_conflict";
  drive_cycle(2'b11, 6'h09, 16'hbeef, 6'h1d, 16'hfeed, 1'b0, '0);  // rows 2 and 7.
  drive_idle();
  read_expect(6'h09, 16'hbeef);
  read_expect(6'h1d, 16'hfeed);
  for (int i = 0; i < CONFLICT_ITER; i++) begin
    a0   = addr_t'(rand_bits(ADDR_W));
    row1 = row_t'(rand_bits(ROW_W));
    if (row1 == a0[ADDR_W-1:VBNK_W]) begin
      row1 = row1 + 1'b1;
    end
    a1 = {row1, a0[VBNK_W-1:0]};
    d0 = data_t'(rand_bits(WIDTH));
    d1 = data_t'(rand_bits(WIDTH));
    drive_cycle(2'b11, a0, d0, a1, d1, 1'b0, '0);
    drive_cycle(2'b00, '0, '0, '0, '0, 1'b1, a0);
    drive_cycle(2'b00, '0, '0, '0, '0, 1'b1, a1);
  end
  for (int a = 0; a < NUM_WORDS; a++) begin
    drive_cycle(2'b00, '0, '0, '0, '0, 1'b1, addr_t'(a));
  end
  drive_idle();
  wait_reads_done();
endtask

task automatic back_to_back_reads();
  int         start;
  logic [1:0] wr;
  addr_t      a0;
  addr_t      a1;
  addr_t      ra;
  data_t      d0;
  data_t      d1;
  test_name = "back_to_back";
  start = n_checks;
  for (int i = 0; i < MIX_CYC; i++) begin
    wr = 2'(rand_bits(2));
    a0 = addr_t'(rand_bits(ADDR_W));
    d0 = data_t'(rand_bits(WIDTH));
    a1 = addr_t'(rand_bits(ADDR_W));
    d1 = data_t'(rand_bits(WIDTH));
    ra = addr_t'(rand_bits(ADDR_W));
    drive_cycle(wr, a0, d0, a1, d1, 1'b1, ra);
  end
  drive_idle();
  wait_reads_done();
  assert (n_checks - start == MIX_CYC) else begin
    $display("%s: %0d reads returned out of %0d", test_name, n_checks - start, MIX_CYC);
    n_other_err++;
  end
endtask

`endif

// File: test/tb_mp_mem.sv
module tb_mp_mem
  import mem_pkg::*;
();

  localparam int NUM_WORDS     = NUM_VROW * NUM_VBNK;
  localparam int RESET_CYC     = 10;
  localparam int CONFLICT_ITER = 200;
  localparam int MIX_CYC       = 150;
  // fill, three cycles per conflict pair, sweep, mix and directed tests, doubled.
  localparam int TIMEOUT = 2 * (RESET_CYC + NUM_WORDS / 2 + 3 * CONFLICT_ITER + NUM_WORDS
                                + MIX_CYC + 100);

  logic        clk;
  logic        arst_n;
  logic [1:0]  write;
  addr_t       wr_adr [2];
  data_t       din [2];
  logic        read;
  addr_t       rd_adr;
  logic        rd_vld;
  data_t       rd_dout;

  data_t       ref_mem [NUM_WORDS];
  data_t       exp_q [$];
  addr_t       adr_q [$];
  int          due_q [$];
  string       name_q [$];

  int          cyc;
  int          n_checks;
  int          n_data_err;
  int          n_other_err;
  string       test_name;
  logic [31:0] lfsr;

  mp_mem_top u_mp_mem_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #5 clk = ~clk;

  function automatic void pop_expected();
    void'(exp_q.pop_front());
    void'(adr_q.pop_front());
    void'(due_q.pop_front());
    void'(name_q.pop_front());
  endfunction

  // reference model, sampled on the same edge as the DUT.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (arst_n) begin
      if (read) begin
        exp_q.push_back(ref_mem[rd_adr]);  // before this edge's writes.
        adr_q.push_back(rd_adr);
        due_q.push_back(cyc + RD_LAT - 1);
        name_q.push_back(test_name);
      end
      if (write[0]) begin
        ref_mem[wr_adr[0]] = din[0];
      end
      if (write[1]) begin
        ref_mem[wr_adr[1]] = din[1];  // port 1 last, so it wins.
      end
    end
  end

  always @(negedge clk) begin
    if (rd_vld) begin
      assert (exp_q.size() > 0) else begin
        $display("rd_vld high at cycle %0d with no read outstanding", cyc);
        n_other_err++;
      end
      if (exp_q.size() > 0) begin
        assert (due_q[0] == cyc) else begin
          $display("%s: read of %h returned at cycle %0d instead of cycle %0d",
                   name_q[0], adr_q[0], cyc, due_q[0]);
          n_other_err++;
        end
        assert (rd_dout === exp_q[0]) else begin
          $display("error %s: addr %h expected %h actual %h",
                   name_q[0], adr_q[0], exp_q[0], rd_dout);
          n_data_err++;
        end
        n_checks++;
        pop_expected();
      end
    end else if (due_q.size() > 0) begin
      assert (due_q[0] > cyc) else begin
        $display("%s: read of %h never raised rd_vld", name_q[0], adr_q[0]);
        n_other_err++;
        pop_expected();
      end
    end
  end

  `include "tb_tasks.svh"

  initial begin
    clk         = 1'b0;
    arst_n      = 1'b0;
    write       = 2'b00;
    wr_adr[0]   = '0;
    wr_adr[1]   = '0;
    din[0]      = '0;
    din[1]      = '0;
    read        = 1'b0;
    rd_adr      = '0;
    cyc         = 0;
    n_checks    = 0;
    n_data_err  = 0;
    n_other_err = 0;
    test_name   = "reset";
    lfsr        = 32'h70fe_3af5;

    repeat (RESET_CYC) @(posedge clk);
    #1;
    arst_n = 1'b1;

    reset_and_single_write();
    dual_write_banks();
    same_address_writes();
    read_during_write();
    fill_memory();
    bank_conflict_writes();
    back_to_back_reads();

    $display("checks %0d, data errors %0d, other errors %0d",
             n_checks, n_data_err, n_other_err);
    if (n_data_err + n_other_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (cyc >= TIMEOUT);
    $display("timeout at cycle %0d with %0d reads outstanding", cyc, exp_q.size());
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: logic/mp_mem_top.sv
module mp_mem_top
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,

  input  logic [1:0] write,
  input  addr_t      wr_adr [2],
  input  data_t      din [2],

  input  logic       read,
  input  addr_t      rd_adr,
  output logic       rd_vld,
  output data_t      rd_dout
);

  row_t                wr_row [2];
  vbnk_t               wr_vbnk [2];
  pbnk_t               wr_pbnk [2];
  pbnk_t               wr_spare [2];

  row_t                rd_row;
  vbnk_t               rd_vbnk;
  pbnk_t               rd_pbnk;

  logic                upd;
  row_t                upd_row;
  vbnk_t               upd_vbnk;
  pbnk_t               upd_pbnk;

  logic [NUM_PBNK-1:0] bank_we;
  row_t                bank_row [NUM_PBNK];
  data_t               bank_data [NUM_PBNK];
  logic [NUM_PBNK-1:0] bank_re;
  row_t                bank_rrow;
  data_t               bank_rdata [NUM_PBNK];

  bank_map u_bank_map (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_row   (wr_row),
    .wr_vbnk  (wr_vbnk),
    .wr_pbnk  (wr_pbnk),
    .wr_spare (wr_spare),
    .rd_row   (rd_row),
    .rd_vbnk  (rd_vbnk),
    .rd_pbnk  (rd_pbnk),
    .upd      (upd),
    .upd_row  (upd_row),
    .upd_vbnk (upd_vbnk),
    .upd_pbnk (upd_pbnk)
  );

  write_steer u_write_steer (
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .wr_pbnk   (wr_pbnk),
    .wr_spare  (wr_spare),
    .bank_we   (bank_we),
    .bank_row  (bank_row),
    .bank_data (bank_data),
    .wr_row    (wr_row),
    .wr_vbnk   (wr_vbnk),
    .upd       (upd),
    .upd_row   (upd_row),
    .upd_vbnk  (upd_vbnk),
    .upd_pbnk  (upd_pbnk)
  );

  read_path u_read_path (
    .clk        (clk),
    .arst_n     (arst_n),
    .read       (read),
    .rd_adr     (rd_adr),
    .rd_pbnk    (rd_pbnk),
    .bank_rdata (bank_rdata),
    .rd_row     (rd_row),
    .rd_vbnk    (rd_vbnk),
    .bank_re    (bank_re),
    .bank_rrow  (bank_rrow),
    .rd_vld     (rd_vld),
    .rd_dout    (rd_dout)
  );

  // one physical bank per slot, spare included.
  for (genvar b = 0; b < NUM_PBNK; b++) begin : g_bank
    sram_1r1w #(
      .DEPTH (NUM_VROW)
    ) u_sram (
      .clk     (clk),
      .we      (bank_we[b]),
      .wr_row  (bank_row[b]),
      .wr_data (bank_data[b]),
      .re      (bank_re[b]),
      .rd_row  (bank_rrow),
      .rd_data (bank_rdata[b])
    );
  end

endmodule

// File: logic/read_path.sv
module read_path
  import mem_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  logic                read,
  input  addr_t               rd_adr,
  input  pbnk_t               rd_pbnk,
  input  data_t               bank_rdata [NUM_PBNK],

  output row_t                rd_row,
  output vbnk_t               rd_vbnk,
  output logic [NUM_PBNK-1:0] bank_re,
  output row_t                bank_rrow,
  output logic                rd_vld,
  output data_t               rd_dout
);

  logic [RD_LAT-1:0] vld_q;
  pbnk_t             sel_q;

  assign rd_row    = addr_row(rd_adr);
  assign rd_vbnk   = addr_bank(rd_adr);
  assign bank_rrow = rd_row;

  always_comb begin
    for (int b = 0; b < NUM_PBNK; b++) begin
      bank_re[b] = read && (rd_pbnk == pbnk_t'(b));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
      sel_q <= '0;
    end else begin
      vld_q <= {vld_q[RD_LAT-2:0], read};
      if (read) begin
        sel_q <= rd_pbnk;  // follows the read into the bank.
      end
    end
  end

  // stage 0 valid means bank data is on its output.
  always_ff @(posedge clk) begin
    if (vld_q[0]) begin
      rd_dout <= bank_rdata[sel_q];
    end
  end

  assign rd_vld = vld_q[RD_LAT-1];

endmodule

// File: logic/write_steer.sv
module write_steer
  import mem_pkg::*;
(
  input  logic [1:0]          write,
  input  addr_t               wr_adr [2],
  input  data_t               din [2],
  input  pbnk_t               wr_pbnk [2],
  input  pbnk_t               wr_spare [2],

  output logic [NUM_PBNK-1:0] bank_we,
  output row_t                bank_row [NUM_PBNK],
  output data_t               bank_data [NUM_PBNK],

  output row_t                wr_row [2],
  output vbnk_t               wr_vbnk [2],
  output logic                upd,
  output row_t                upd_row,
  output vbnk_t               upd_vbnk,
  output pbnk_t               upd_pbnk
);

  logic  same_adr;
  logic  wr_en0;
  logic  wr_en1;
  logic  conflict;
  pbnk_t tgt1;

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      wr_row[p]  = addr_row(wr_adr[p]);
      wr_vbnk[p] = addr_bank(wr_adr[p]);
    end
  end

  assign same_adr = write[0] && write[1] && (wr_adr[0] == wr_adr[1]);
  assign wr_en0   = write[0] && !same_adr;  // port 1 wins.
  assign wr_en1   = write[1];

  // same physical bank means different rows here.
  assign conflict = wr_en0 && wr_en1 && (wr_pbnk[0] == wr_pbnk[1]);
  assign tgt1     = conflict ? wr_spare[1] : wr_pbnk[1];

  always_comb begin
    for (int b = 0; b < NUM_PBNK; b++) begin
      bank_we[b]   = (wr_en0 && wr_pbnk[0] == pbnk_t'(b)) || (wr_en1 && tgt1 == pbnk_t'(b));
      bank_row[b]  = wr_row[0];
      bank_data[b] = din[0];
      if (wr_en1 && tgt1 == pbnk_t'(b)) begin
        bank_row[b]  = wr_row[1];
        bank_data[b] = din[1];
      end
    end
  end

  // moved write owns the spare from now on.
  assign upd      = conflict;
  assign upd_row  = wr_row[1];
  assign upd_vbnk = wr_vbnk[1];
  assign upd_pbnk = wr_spare[1];

endmodule

// File: logic/bank_map.sv
module bank_map
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,

  // write port lookups
  input  row_t  wr_row [2],
  input  vbnk_t wr_vbnk [2],
  output pbnk_t wr_pbnk [2],
  output pbnk_t wr_spare [2],

  // read lookup
  input  row_t  rd_row,
  input  vbnk_t rd_vbnk,
  output pbnk_t rd_pbnk,

  // remap command
  input  logic  upd,
  input  row_t  upd_row,
  input  vbnk_t upd_vbnk,
  input  pbnk_t upd_pbnk
);

  pbnk_t map_q   [NUM_VROW][NUM_VBNK];
  pbnk_t spare_q [NUM_VROW];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < NUM_VROW; r++) begin
        for (int v = 0; v < NUM_VBNK; v++) begin
          map_q[r][v] <= pbnk_t'(v);  // identity.
        end
        spare_q[r] <= pbnk_t'(NUM_PBNK - 1);
      end
    end else if (upd) begin
      map_q[upd_row][upd_vbnk] <= upd_pbnk;
      spare_q[upd_row]         <= map_q[upd_row][upd_vbnk];  // vacated bank.
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      wr_pbnk[p]  = map_q[wr_row[p]][wr_vbnk[p]];
      wr_spare[p] = spare_q[wr_row[p]];
    end
  end

  assign rd_pbnk = map_q[rd_row][rd_vbnk];

endmodule

// File: logic/sram_1r1w.sv
module sram_1r1w
  import mem_pkg::*;
#(
  parameter int DEPTH = NUM_VROW
) (
  input  logic  clk,
  input  logic  we,
  input  row_t  wr_row,
  input  data_t wr_data,
  input  logic  re,
  input  row_t  rd_row,
  output data_t rd_data
);

  data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
  end

  // read sees the array before this edge's write.
  always_ff @(posedge clk) begin
    if (re) begin
      rd_data <= mem[rd_row];  // old data on collision.
    end
  end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

  localparam int WIDTH    = 16;
  localparam int NUM_VBNK = 4;
  localparam int NUM_PBNK = NUM_VBNK + 1;  // one spare per row.
  localparam int NUM_VROW = 16;

  localparam int VBNK_W = $clog2(NUM_VBNK);
  localparam int PBNK_W = $clog2(NUM_PBNK);
  localparam int ROW_W  = $clog2(NUM_VROW);
  localparam int ADDR_W = ROW_W + VBNK_W;

  localparam int RD_LAT = 2;  // read strobe to rd_vld.

  typedef logic [WIDTH-1:0]  data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [VBNK_W-1:0] vbnk_t;
  typedef logic [PBNK_W-1:0] pbnk_t;

  // logical bank sits in the low address bits.
  function automatic vbnk_t addr_bank(addr_t adr);
    return adr[VBNK_W-1:0];
  endfunction

  function automatic row_t addr_row(addr_t adr);
    return adr[ADDR_W-1 -: ROW_W];
  endfunction

endpackage
